/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tetris_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
rtl/tetris_game_pkg.sv
rtl/tetris_shape_pkg.sv
rtl/game_fsm.sv
rtl/drop_timer.sv
rtl/piece_ctrl.sv
rtl/board_store.sv
rtl/tetris_top.sv
verification/tetris_tb.sv

/* rtl/board_store.sv */
`timescale 1ns/1ps
`default_nettype none

module board_store (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            spawn,
	input  wire                            place,
	input  wire                            clear_start,
	input  tetris_game_pkg::col_t          piece_x,
	input  tetris_game_pkg::row_idx_t      piece_y,
	input  tetris_shape_pkg::piece_mask_t  piece_mask,
	input  tetris_game_pkg::row_idx_t      row_sel,
	output tetris_game_pkg::board_row_t [tetris_game_pkg::BOARD_ROWS-1:0] board_cells,
	output tetris_game_pkg::board_row_t    row_bits,
	output logic                           clear_done,
	output logic                           overflow,
	output logic [7:0]                     score
);
	import tetris_game_pkg::*;

	board_row_t [BOARD_ROWS-1:0] board;
	row_idx_t rd_ptr;  // row being scanned
	row_idx_t wr_ptr;  // next slot for a kept row
	logic     scan_on;
	logic     scan_act;
	logic     row_full;
	int       wr_after;

	assign scan_act   = clear_start || scan_on;
	assign row_full   = &board[rd_ptr];
	assign clear_done = scan_act && (rd_ptr == 5'd0);
	assign wr_after   = int'(wr_ptr) - (row_full ? 0 : 1);  // lowest kept slot minus one

	assign board_cells = board;
	assign overflow    = |board[HIDDEN_ROWS-1:0];
	assign row_bits    = (row_sel < BOARD_ROWS) ? board[row_sel] : '0;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			board   <= '0;
			rd_ptr  <= LAST_ROW;
			wr_ptr  <= LAST_ROW;
			scan_on <= 1'b0;
			score   <= 8'd0;
		end else begin
			if (spawn) begin
				rd_ptr <= LAST_ROW;
				wr_ptr <= LAST_ROW;
			end

			// ==============================
			// lock the piece into the board
			// ==============================
			if (place) begin
				for (int r = 0; r < 4; r++) begin
					for (int c = 0; c < 4; c++) begin
						if (piece_mask[4*r+c] && int'(piece_y) + r < BOARD_ROWS &&
								int'(piece_x) + c < BOARD_W) begin
							board[int'(piece_y) + r][int'(piece_x) + c] <= 1'b1;
						end
					end
				end
			end

			// ==============================
			// row clear, bottom to top
			// ==============================
			if (scan_act) begin
				if (!row_full) begin
					board[wr_ptr] <= board[rd_ptr];  // compact in place
					wr_ptr <= wr_ptr - 5'd1;
				end else begin
					score <= score + 8'd1;  // wraps
				end
				if (clear_done) begin
					scan_on <= 1'b0;
					for (int r = 0; r < BOARD_ROWS; r++) begin
						if (r <= wr_after)
							board[r] <= '0;  // vacated rows on top
					end
				end else begin
					scan_on <= 1'b1;
					rd_ptr  <= rd_ptr - 5'd1;
				end
			end
		end
	end

	a_wr_not_below_rd: assert property (@(posedge clk) disable iff (!rst)
		wr_ptr >= rd_ptr);

endmodule

`default_nettype wire

/* rtl/drop_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module drop_timer (
	input  wire        clk,
	input  wire        rst,
	input  wire        speed_up,
	input  wire        speed_down,
	input  wire        fall_en,
	output logic       drop_tick,
	output logic [1:0] speed_level
);
	import tetris_game_pkg::*;

	localparam logic [1:0] TOP_LEVEL = 2'(SPEED_LEVELS - 1);

	logic [6:0] cnt;
	logic [6:0] reload;

	assign reload    = 7'(DROP_PERIOD[speed_level] - 1);
	assign drop_tick = (cnt == 7'd0);  // counter is held at reload outside fall

	// speed level saturates at both ends
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			speed_level <= 2'd0;
		end else if (speed_up && !speed_down && speed_level != TOP_LEVEL) begin
			speed_level <= speed_level + 2'd1;
		end else if (speed_down && !speed_up && speed_level != 2'd0) begin
			speed_level <= speed_level - 2'd1;
		end
	end

	// down-counter held at reload while not falling
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= 7'(DROP_PERIOD[0] - 1);
		end else if (!fall_en || drop_tick) begin
			cnt <= reload;  // new level takes effect here
		end else begin
			cnt <= cnt - 7'd1;
		end
	end

	a_tick_in_fall: assert property (@(posedge clk) disable iff (!rst)
		drop_tick |-> fall_en);

endmodule

`default_nettype wire

/* rtl/game_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        key_valid,
	input  tetris_game_pkg::key_cmd_t  key_cmd,
	input  wire                        landed,
	input  wire                        clear_done,
	input  wire                        overflow,
	output logic                       spawn,
	output logic                       fall_en,
	output logic                       place,
	output logic                       clear_start,
	output tetris_game_pkg::game_phase_t game_phase
);
	import tetris_game_pkg::*;

	game_state_t state;
	game_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			IDLE:      if (key_valid && key_cmd == CMD_START) state_next = NEW_PIECE;
			NEW_PIECE: state_next = FALL;
			FALL:      if (landed) state_next = PLACE;
			PLACE:     state_next = CLEAR;
			CLEAR:     if (clear_done) state_next = overflow ? OVER : NEW_PIECE;
			OVER:      state_next = OVER;  // left only through reset
			default:   state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state       <= IDLE;
			clear_start <= 1'b0;
		end else begin
			state       <= state_next;
			clear_start <= (state == PLACE);  // first cycle of CLEAR
		end
	end

	// control decode
	assign spawn   = (state == NEW_PIECE);
	assign fall_en = (state == FALL);
	assign place   = (state == PLACE);

	always_comb begin
		case (state)
			IDLE:    game_phase = READY;
			OVER:    game_phase = ENDED;
			default: game_phase = PLAYING;
		endcase
	end

	a_state_legal: assert property (@(posedge clk) disable iff (!rst)
		state inside {IDLE, NEW_PIECE, FALL, PLACE, CLEAR, OVER});

endmodule

`default_nettype wire

/* rtl/piece_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_ctrl (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          spawn,
	input  wire                          fall_en,
	input  wire                          drop_tick,
	input  wire                          key_valid,
	input  tetris_game_pkg::key_cmd_t    key_cmd,
	input  tetris_game_pkg::board_row_t [tetris_game_pkg::BOARD_ROWS-1:0] board_cells,
	output logic                         landed,
	output tetris_game_pkg::col_t        piece_x,
	output tetris_game_pkg::row_idx_t    piece_y,
	output tetris_shape_pkg::shape_t     piece_shape,
	output tetris_shape_pkg::rot_t       piece_rot,
	output tetris_shape_pkg::piece_mask_t piece_mask
);
	import tetris_game_pkg::*;
	import tetris_shape_pkg::*;

	// true if any mask cell is off the board or on a filled cell
	function automatic logic collides(input int x, input int y, input piece_mask_t m,
			input board_row_t [BOARD_ROWS-1:0] cells);
		logic hit;
		int cx;
		int cy;
		hit = 1'b0;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				cx = x + c;
				cy = y + r;
				if (m[4*r+c]) begin
					if (cx < 0 || cx >= BOARD_W || cy < 0 || cy >= BOARD_ROWS) begin
						hit = 1'b1;
					end else if (cells[cy][cx]) begin
						hit = 1'b1;
					end
				end
			end
		end
		return hit;
	endfunction

	logic [2:0] lfsr;
	logic [2:0] lfsr_next;
	rot_t       rot_up;
	rot_t       rot_dn;
	logic       down_hit;

	assign lfsr_next   = {lfsr[1], lfsr[2] ^ lfsr[0], lfsr[1] ^ lfsr[0]};
	assign piece_shape = (lfsr == 3'd7) ? O : shape_t'(lfsr);  // 7 folds onto O
	assign piece_mask  = shape_mask(piece_shape, piece_rot);
	assign rot_up      = piece_rot + 2'd1;
	assign rot_dn      = piece_rot - 2'd1;

	assign down_hit = collides(int'(piece_x), int'(piece_y) + 1, piece_mask, board_cells);
	assign landed   = fall_en && drop_tick && down_hit;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			lfsr      <= LFSR_SEED;
			piece_x   <= SPAWN_X;
			piece_y   <= SPAWN_Y;
			piece_rot <= 2'd0;
		end else if (spawn) begin
			lfsr      <= lfsr_next;
			piece_x   <= SPAWN_X;
			piece_y   <= SPAWN_Y;
			piece_rot <= 2'd0;
		end else if (fall_en && drop_tick) begin
			// a drop wins over a key in the same cycle
			if (!down_hit) begin
				piece_y <= piece_y + 5'd1;
			end
		end else if (fall_en && key_valid) begin
			case (key_cmd)
				CMD_LEFT: begin
					if (!collides(int'(piece_x) - 1, int'(piece_y), piece_mask, board_cells))
						piece_x <= piece_x - 4'd1;
				end
				CMD_RIGHT: begin
					if (!collides(int'(piece_x) + 1, int'(piece_y), piece_mask, board_cells))
						piece_x <= piece_x + 4'd1;
				end
				CMD_ROT_CW: begin
					if (!collides(int'(piece_x), int'(piece_y),
							shape_mask(piece_shape, rot_up), board_cells))
						piece_rot <= rot_up;
				end
				CMD_ROT_CCW: begin
					if (!collides(int'(piece_x), int'(piece_y),
							shape_mask(piece_shape, rot_dn), board_cells))
						piece_rot <= rot_dn;
				end
				default: ;  // start has no effect here
			endcase
		end
	end

	// pose stays on the board, checked against an empty field
	a_pose_in_board: assert property (@(posedge clk) disable iff (!rst)
		!collides(int'(piece_x), int'(piece_y), piece_mask, '0));

endmodule

`default_nettype wire

/* rtl/tetris_game_pkg.sv */
`default_nettype none

package tetris_game_pkg;

	// ==============================
	// board geometry
	// ==============================
	localparam int BOARD_W     = 10;
	localparam int BOARD_ROWS  = 24;
	localparam int HIDDEN_ROWS = 4;  // rows 0..3 sit above the visible field

	typedef logic [BOARD_W-1:0] board_row_t;  // bit c is column c
	typedef logic [4:0]         row_idx_t;
	typedef logic [3:0]         col_t;

	localparam row_idx_t LAST_ROW = row_idx_t'(BOARD_ROWS - 1);  // bottom row

	// ==============================
	// game control
	// ==============================
	typedef enum logic [2:0] {
		IDLE,
		NEW_PIECE,
		FALL,
		PLACE,
		CLEAR,
		OVER
	} game_state_t;

	typedef enum logic [1:0] {
		READY,
		PLAYING,
		ENDED
	} game_phase_t;

	// key opcodes, sampled with key_valid
	typedef enum logic [2:0] {
		CMD_START,
		CMD_LEFT,
		CMD_RIGHT,
		CMD_ROT_CW,
		CMD_ROT_CCW
	} key_cmd_t;

	// drop period in clk cycles, slowest first
	localparam int SPEED_LEVELS = 4;
	localparam int DROP_PERIOD [SPEED_LEVELS] = '{64, 48, 32, 24};

endpackage

`default_nettype wire

/* rtl/tetris_shape_pkg.sv */
`default_nettype none

package tetris_shape_pkg;

	typedef enum logic [2:0] {
		O = 3'd0,
		I = 3'd1,
		S = 3'd2,
		Z = 3'd3,
		L = 3'd4,
		J = 3'd5,
		T = 3'd6
	} shape_t;

	typedef logic [1:0]  rot_t;
	typedef logic [15:0] piece_mask_t;  // bit 4*r+c -> row r, col c

	// spawn pose and lfsr start value
	localparam logic [3:0] SPAWN_X   = 4'd4;
	localparam logic [4:0] SPAWN_Y   = 5'd0;
	localparam logic [2:0] LFSR_SEED = 3'd3;  // first step gives T

	// ==============================
	// shape table, low nibble is the top row
	// ==============================
	function automatic piece_mask_t shape_mask(input shape_t s, input rot_t r);
		piece_mask_t m;
		case (s)
			O: m = 16'h0033;
			I: m = r[0] ? 16'h1111 : 16'h000f;  // two poses only
			S: m = r[0] ? 16'h0231 : 16'h0036;
			Z: m = r[0] ? 16'h0132 : 16'h0063;
			L: begin
				case (r)
					2'd0: m = 16'h0074;
					2'd1: m = 16'h0223;
					2'd2: m = 16'h0017;
					default: m = 16'h0311;
				endcase
			end
			J: begin
				case (r)
					2'd0: m = 16'h0071;
					2'd1: m = 16'h0322;
					2'd2: m = 16'h0047;
					default: m = 16'h0113;
				endcase
			end
			T: begin
				case (r)
					2'd0: m = 16'h0027;
					2'd1: m = 16'h0131;
					2'd2: m = 16'h0072;
					default: m = 16'h0232;
				endcase
			end
			default: m = 16'h0033;
		endcase
		return m;
	endfunction

endpackage

`default_nettype wire

/* rtl/tetris_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_top (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          key_valid,
	input  tetris_game_pkg::key_cmd_t    key_cmd,
	input  wire                          speed_up,
	input  wire                          speed_down,
	input  tetris_game_pkg::row_idx_t    row_sel,
	output tetris_game_pkg::board_row_t  row_bits,
	output tetris_game_pkg::col_t        piece_x,
	output tetris_game_pkg::row_idx_t    piece_y,
	output tetris_shape_pkg::shape_t     piece_shape,
	output tetris_shape_pkg::rot_t       piece_rot,
	output logic [7:0]                   score,
	output logic [1:0]                   speed_level,
	output tetris_game_pkg::game_phase_t game_phase
);
	import tetris_game_pkg::*;
	import tetris_shape_pkg::*;

	// fsm strobes
	logic spawn;
	logic fall_en;
	logic place;
	logic clear_start;
	// datapath status
	logic drop_tick;
	logic landed;
	logic clear_done;
	logic overflow;
	piece_mask_t piece_mask;
	board_row_t [BOARD_ROWS-1:0] board_cells;

	game_fsm u_fsm (
		.clk(clk), .rst(rst),
		.key_valid(key_valid), .key_cmd(key_cmd),
		.landed(landed), .clear_done(clear_done), .overflow(overflow),
		.spawn(spawn), .fall_en(fall_en), .place(place), .clear_start(clear_start),
		.game_phase(game_phase)
	);

	drop_timer u_timer (
		.clk(clk), .rst(rst),
		.speed_up(speed_up), .speed_down(speed_down), .fall_en(fall_en),
		.drop_tick(drop_tick), .speed_level(speed_level)
	);

	piece_ctrl u_piece (
		.clk(clk), .rst(rst),
		.spawn(spawn), .fall_en(fall_en), .drop_tick(drop_tick),
		.key_valid(key_valid), .key_cmd(key_cmd), .board_cells(board_cells),
		.landed(landed), .piece_x(piece_x), .piece_y(piece_y),
		.piece_shape(piece_shape), .piece_rot(piece_rot), .piece_mask(piece_mask)
	);

	board_store u_board (
		.clk(clk), .rst(rst),
		.spawn(spawn), .place(place), .clear_start(clear_start),
		.piece_x(piece_x), .piece_y(piece_y), .piece_mask(piece_mask),
		.row_sel(row_sel), .board_cells(board_cells), .row_bits(row_bits),
		.clear_done(clear_done), .overflow(overflow), .score(score)
	);

endmodule

`default_nettype wire

/* verification/tetris_stim.txt */
// one word per line: op(1 hex) sel(2 hex) val(5 hex)
// op 1 key sel=cmd, 2 speed sel=0 up, 3 wait y move val=interval, 4 wait phase, 5 wait spawn
// op 6 idle, 7 row sel, 8 rows sel..23, 9 x, a y, b rot, c shape, d score, e phase, f level
8_00_00000 // empty board after reset
e_00_00000
d_00_00000
f_00_00000
1_00_00003 // start
e_00_00001
c_00_00006 // T first
9_00_00004
a_00_00000
b_00_00000
3_00_00000
3_00_00040 // 64 cycles at level 0
2_00_00001
2_00_00001
2_00_00001
f_00_00003
2_00_00001 // saturates
f_00_00003
3_00_00000
3_00_00018 // 24 cycles at level 3
a_00_00004
1_02_00000 // right
9_00_00005
1_01_00000
9_00_00004
3_00_00000
1_03_00000 // rotations
b_00_00001
1_04_00000
b_00_00000
1_04_00000
b_00_00003
1_03_00000
b_00_00000
1_03_00000
1_03_00000
b_00_00002
3_00_00000
1_01_00000 // six lefts, wall at x 0
1_01_00000
1_01_00000
1_01_00000
1_01_00000
1_01_00000
9_00_00000
a_00_00006
5_00_00000 // T rests at y 22
c_00_00000
7_16_00002
7_17_00007
d_00_00000
9_00_00004
1_01_00000 // O to x 3
9_00_00003
5_00_00000
c_00_00004 // L to x 5
1_02_00000
9_00_00005
5_00_00000
c_00_00002 // S to x 0
1_01_00000
1_01_00000
1_01_00000
1_01_00000
9_00_00000
5_00_00000
c_00_00005 // J upright to x 8
1_03_00000
1_02_00000
1_02_00000
1_02_00000
1_02_00000
9_00_00008
5_00_00000 // row 23 cleared
c_00_00001
d_00_00001
7_17_0029a
7_16_00203
7_15_00006
7_14_00000
4_00_00002 // untouched stack ends the game
e_00_00002
c_00_00004
9_00_00004
a_00_00002
b_00_00000
d_00_00001
7_03_00070
7_02_00040
1_01_00000
1_03_00000
1_02_00000
1_00_0001e
9_00_00004
a_00_00002
b_00_00000
d_00_00001
e_00_00002
0_00_00000

/* verification/tetris_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_tb;
	import tetris_game_pkg::*;
	import tetris_shape_pkg::*;

	localparam int STIM_DEPTH    = 256;
	localparam int MOVE_LIMIT    = 200;    // cycles for one drop step
	localparam int SPAWN_LIMIT   = 2000;   // fall, place and clear of one piece
	localparam int PHASE_LIMIT   = 20000;

	logic        clk;
	logic        rst;
	logic        key_valid;
	key_cmd_t    key_cmd;
	logic        speed_up;
	logic        speed_down;
	row_idx_t    row_sel;
	board_row_t  row_bits;
	col_t        piece_x;
	row_idx_t    piece_y;
	shape_t      piece_shape;
	rot_t        piece_rot;
	logic [7:0]  score;
	logic [1:0]  speed_level;
	game_phase_t game_phase;

	logic [31:0] stim_mem [STIM_DEPTH];

	tetris_top dut (
		.clk(clk), .rst(rst),
		.key_valid(key_valid), .key_cmd(key_cmd),
		.speed_up(speed_up), .speed_down(speed_down), .row_sel(row_sel),
		.row_bits(row_bits), .piece_x(piece_x), .piece_y(piece_y),
		.piece_shape(piece_shape), .piece_rot(piece_rot), .score(score),
		.speed_level(speed_level), .game_phase(game_phase)
	);

	always #5 clk = ~clk;

	// ==============================
	// checking and failure
	// ==============================
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
				name, actual, expected));
	endtask

	task automatic step_cycle;
		@(posedge clk);
		#1;
	endtask

	// ==============================
	// stimulus
	// ==============================
	task automatic send_key(input logic [7:0] cmd, input int idle);
		key_cmd   = key_cmd_t'(cmd[2:0]);
		key_valid = 1'b1;
		step_cycle();
		key_valid = 1'b0;
		repeat (idle) step_cycle();
	endtask

	task automatic pulse_speed(input logic [7:0] dir, input int idle);
		speed_up   = (dir == 8'd0);
		speed_down = (dir != 8'd0);
		step_cycle();
		speed_up   = 1'b0;
		speed_down = 1'b0;
		repeat (idle) step_cycle();
	endtask

	// counts cycles until the piece row moves
	task automatic wait_y_move(input int expected);
		row_idx_t start_y;
		int cycles;
		start_y = piece_y;
		cycles  = 0;
		while (piece_y == start_y) begin
			step_cycle();
			cycles++;
			if (cycles > MOVE_LIMIT)
				report_failure("Timeout: the piece did not move down");
		end
		if (expected != 0)
			check_value("drop interval", 32'(cycles), 32'(expected));
	endtask

	// returns once piece_y has left target and come back to it
	task automatic wait_y_return(input row_idx_t target);
		logic seen_other;
		int cycles;
		seen_other = (piece_y != target);
		cycles     = 0;
		while (!(seen_other && piece_y == target)) begin
			step_cycle();
			cycles++;
			if (piece_y != target)
				seen_other = 1'b1;
			if (cycles > SPAWN_LIMIT)
				report_failure("Timeout: no new piece was spawned");
		end
	endtask

	task automatic wait_phase(input logic [1:0] target);
		int cycles;
		cycles = 0;
		while (game_phase != game_phase_t'(target)) begin
			step_cycle();
			cycles++;
			if (cycles > PHASE_LIMIT)
				report_failure("Timeout: the game never reached the expected phase");
		end
	endtask

	task automatic check_rows_from(input row_idx_t first, input board_row_t expected);
		for (int r = int'(first); r < BOARD_ROWS; r++) begin
			row_sel = row_idx_t'(r);
			#0.1;
			check_value($sformatf("row_bits[%0d]", r), 32'(row_bits), 32'(expected));
		end
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		logic [31:0] word;
		logic [3:0]  op;
		logic [7:0]  sel;
		logic [19:0] val;
		int          idx;
		logic        done;
		clk        = 1'b0;
		rst        = 1'b0;
		key_valid  = 1'b0;
		key_cmd    = CMD_START;
		speed_up   = 1'b0;
		speed_down = 1'b0;
		row_sel    = '0;
		$readmemh("verification/tetris_stim.txt", stim_mem);

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		step_cycle();

		idx  = 0;
		done = 1'b0;
		while (!done) begin
			if (idx >= STIM_DEPTH)
				report_failure("The stimulus file has no end line");
			word = stim_mem[idx];
			if ($isunknown(word) || (idx == 0 && word == 32'd0))
				report_failure("The stimulus file is missing or has no end line");
			op   = word[31:28];
			sel  = word[27:20];
			val  = word[19:0];
			case (op)
				4'h0: done = 1'b1;
				4'h1: send_key(sel, int'(val));
				4'h2: pulse_speed(sel, int'(val));
				4'h3: wait_y_move(int'(val));
				4'h4: wait_phase(val[1:0]);
				4'h5: wait_y_return(row_idx_t'(val));
				4'h6: repeat (int'(val)) step_cycle();
				4'h7: begin
					row_sel = row_idx_t'(sel);
					#0.1;
					check_value($sformatf("row_bits[%0d]", sel), 32'(row_bits), 32'(val));
				end
				4'h8: check_rows_from(row_idx_t'(sel), board_row_t'(val));
				4'h9: check_value("piece_x", 32'(piece_x), 32'(val));
				4'ha: check_value("piece_y", 32'(piece_y), 32'(val));
				4'hb: check_value("piece_rot", 32'(piece_rot), 32'(val));
				4'hc: check_value("piece_shape", 32'(piece_shape), 32'(val));
				4'hd: check_value("score", 32'(score), 32'(val));
				4'he: check_value("game_phase", 32'(game_phase), 32'(val));
				default: check_value("speed_level", 32'(speed_level), 32'(val));
			endcase
			idx++;
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire
